/* design/r5p_pkg.sv */
`default_nettype none

package r5p_pkg;

  //////////////////////////////
  // word types
  //////////////////////////////

  // register and bus data
  typedef logic [31:0] xw_t;
  // byte address
  typedef logic [31:0] adr_t;
  // raw instruction
  typedef logic [31:0] op32_t;
  // byte lanes of a word
  typedef logic [3:0] sel_t;

  //////////////////////////////
  // datapath selects
  //////////////////////////////

  // first ALU operand
  typedef enum logic [0:0] {
    A1_RS1,
    A1_PC
  } a1_t;

  // second ALU operand
  typedef enum logic [0:0] {
    A2_RS2,
    A2_IMM
  } a2_t;

  // ALU operation, PASS2 forwards operand 2 for LUI
  typedef enum logic [3:0] {
    ADD,
    SUB,
    SLL,
    SLT,
    SLTU,
    XOR,
    SRL,
    SRA,
    OR,
    AND,
    PASS2
  } alu_op_t;

  // branch condition
  typedef enum logic [2:0] {
    BEQ,
    BNE,
    BLT,
    BGE,
    BLTU,
    BGEU,
    JMP,
    NONE
  } br_op_t;

  // next PC source
  typedef enum logic [0:0] {
    PC_PCN,
    PC_ALU
  } pc_t;

  // write-back source
  typedef enum logic [1:0] {
    WB_NONE,
    WB_ALU,
    WB_MEM,
    WB_PCN
  } wb_t;

  // store size
  typedef enum logic [1:0] {
    SZ_B,
    SZ_H,
    SZ_W
  } sz_t;

  //////////////////////////////
  // decoder output
  //////////////////////////////

  typedef struct packed {
    a1_t     a1;
    a2_t     a2;
    alu_op_t alu;
    br_op_t  br;
    pc_t     pc;
    wb_t     wb;
    // load/store enable, write enable, size
    logic    ls_en;
    logic    ls_we;
    sz_t     sz;
    xw_t     imm;
  } ctl_t;

endpackage

`default_nettype wire

/* design/r5p_gpr_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface r5p_gpr_if #(
  parameter int unsigned RF_AW = 5
);

  // read addresses and data
  logic [RF_AW-1:0] rs1;
  logic [RF_AW-1:0] rs2;
  r5p_pkg::xw_t     rd1;
  r5p_pkg::xw_t     rd2;
  // write port
  logic [RF_AW-1:0] rd;
  logic             we;
  r5p_pkg::xw_t     wd;

  // core side drives addresses and write data
  modport core (output rs1, rs2, rd, we, wd, input rd1, rd2);
  // register file side answers the reads
  modport file (input rs1, rs2, rd, we, wd, output rd1, rd2);

endinterface

`default_nettype wire

/* design/r5p_dec.sv */
`timescale 1ns/1ps
`default_nettype none

module r5p_dec (
  input  wire r5p_pkg::op32_t op,
  output r5p_pkg::ctl_t       ctl,
  output logic                ill
);

  // major opcodes of the supported subset
  localparam logic [6:0] OPC_LUI   = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC = 7'b0010111;
  localparam logic [6:0] OPC_JAL   = 7'b1101111;
  localparam logic [6:0] OPC_JALR  = 7'b1100111;
  localparam logic [6:0] OPC_BR    = 7'b1100011;
  localparam logic [6:0] OPC_LD    = 7'b0000011;
  localparam logic [6:0] OPC_ST    = 7'b0100011;
  localparam logic [6:0] OPC_OPI   = 7'b0010011;
  localparam logic [6:0] OPC_OP    = 7'b0110011;

  logic [6:0]        opc;
  logic [2:0]        f3;
  logic [6:0]        f7;
  logic              f7_ok;
  r5p_pkg::alu_op_t  alu_f3;
  r5p_pkg::xw_t      imm_i;
  r5p_pkg::xw_t      imm_s;
  r5p_pkg::xw_t      imm_b;
  r5p_pkg::xw_t      imm_u;
  r5p_pkg::xw_t      imm_j;

  assign opc = op[6:0];
  assign f3  = op[14:12];
  assign f7  = op[31:25];

  //////////////////////////////
  // immediates
  //////////////////////////////

  assign imm_i = {{20{op[31]}}, op[31:20]};
  assign imm_s = {{20{op[31]}}, op[31:25], op[11:7]};
  assign imm_b = {{19{op[31]}}, op[31], op[7], op[30:25], op[11:8], 1'b0};
  assign imm_u = {op[31:12], 12'h000};
  assign imm_j = {{11{op[31]}}, op[31], op[19:12], op[20], op[30:21], 1'b0};

  // funct3 to ALU op, shared by OP and OP-IMM
  always_comb begin
    case (f3)
      3'b000:  alu_f3 = (opc == OPC_OP && f7[5]) ? r5p_pkg::SUB : r5p_pkg::ADD;
      3'b001:  alu_f3 = r5p_pkg::SLL;
      3'b010:  alu_f3 = r5p_pkg::SLT;
      3'b011:  alu_f3 = r5p_pkg::SLTU;
      3'b100:  alu_f3 = r5p_pkg::XOR;
      3'b101:  alu_f3 = f7[5] ? r5p_pkg::SRA : r5p_pkg::SRL;
      3'b110:  alu_f3 = r5p_pkg::OR;
      default: alu_f3 = r5p_pkg::AND;
    endcase
  end

  // funct7 is zero, or 0100000 for SRA and for SUB (OP only)
  assign f7_ok = (f7 == 7'b0000000) ||
                 (f7 == 7'b0100000 && (f3 == 3'b101 || (f3 == 3'b000 && opc == OPC_OP)));

  //////////////////////////////
  // control decode
  //////////////////////////////

  always_comb begin
    // defaults describe a no-op with PC plus 4
    ctl.a1    = r5p_pkg::A1_RS1;
    ctl.a2    = r5p_pkg::A2_IMM;
    ctl.alu   = r5p_pkg::ADD;
    ctl.br    = r5p_pkg::NONE;
    ctl.pc    = r5p_pkg::PC_PCN;
    ctl.wb    = r5p_pkg::WB_NONE;
    ctl.ls_en = 1'b0;
    ctl.ls_we = 1'b0;
    ctl.sz    = r5p_pkg::SZ_W;
    ctl.imm   = imm_i;
    ill       = 1'b0;
    case (opc)
      OPC_LUI: begin
        ctl.alu = r5p_pkg::PASS2;
        ctl.imm = imm_u;
        ctl.wb  = r5p_pkg::WB_ALU;
      end
      OPC_AUIPC: begin
        ctl.a1  = r5p_pkg::A1_PC;
        ctl.imm = imm_u;
        ctl.wb  = r5p_pkg::WB_ALU;
      end
      OPC_JAL: begin
        ctl.a1  = r5p_pkg::A1_PC;
        ctl.imm = imm_j;
        ctl.br  = r5p_pkg::JMP;
        ctl.pc  = r5p_pkg::PC_ALU;
        ctl.wb  = r5p_pkg::WB_PCN;
      end
      OPC_JALR: begin
        ctl.br  = r5p_pkg::JMP;
        ctl.pc  = r5p_pkg::PC_ALU;
        ctl.wb  = r5p_pkg::WB_PCN;
        ill     = (f3 != 3'b000);
      end
      OPC_BR: begin
        // target is PC plus B immediate, compare is on the register values
        ctl.a1  = r5p_pkg::A1_PC;
        ctl.imm = imm_b;
        ctl.pc  = r5p_pkg::PC_ALU;
        case (f3)
          3'b000:  ctl.br = r5p_pkg::BEQ;
          3'b001:  ctl.br = r5p_pkg::BNE;
          3'b100:  ctl.br = r5p_pkg::BLT;
          3'b101:  ctl.br = r5p_pkg::BGE;
          3'b110:  ctl.br = r5p_pkg::BLTU;
          3'b111:  ctl.br = r5p_pkg::BGEU;
          default: ill    = 1'b1;
        endcase
      end
      OPC_LD: begin
        // word loads only
        ctl.ls_en = 1'b1;
        ctl.wb    = r5p_pkg::WB_MEM;
        ill       = (f3 != 3'b010);
      end
      OPC_ST: begin
        ctl.imm   = imm_s;
        ctl.ls_en = 1'b1;
        ctl.ls_we = 1'b1;
        case (f3)
          3'b000:  ctl.sz = r5p_pkg::SZ_B;
          3'b001:  ctl.sz = r5p_pkg::SZ_H;
          3'b010:  ctl.sz = r5p_pkg::SZ_W;
          default: ill    = 1'b1;
        endcase
      end
      OPC_OPI: begin
        ctl.alu = alu_f3;
        ctl.wb  = r5p_pkg::WB_ALU;
        // funct7 only matters for shifts
        ill     = (f3 == 3'b001 || f3 == 3'b101) && !f7_ok;
      end
      OPC_OP: begin
        ctl.a2  = r5p_pkg::A2_RS2;
        ctl.alu = alu_f3;
        ctl.wb  = r5p_pkg::WB_ALU;
        ill     = !f7_ok;
      end
      default: begin
        ill = 1'b1;
      end
    endcase
    // nothing of an illegal word may reach the buses or the file
    if (ill) begin
      ctl.wb    = r5p_pkg::WB_NONE;
      ctl.ls_en = 1'b0;
      ctl.ls_we = 1'b0;
      ctl.br    = r5p_pkg::NONE;
      ctl.pc    = r5p_pkg::PC_PCN;
    end
  end

endmodule

`default_nettype wire

/* design/r5p_gpr.sv */
`timescale 1ns/1ps
`default_nettype none

module r5p_gpr #(
  parameter int unsigned RF_AW = 5
)(
  input wire logic clk,
  input wire logic rst,
  r5p_gpr_if.file  bus
);

  localparam int unsigned NR = 2**RF_AW;

  r5p_pkg::xw_t regs [NR];

  // single write port, x0 never written
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < NR; i++) begin
        regs[i] <= '0;
      end
    end else if (bus.we && bus.rd != '0) begin
      regs[bus.rd] <= bus.wd;
    end
  end

  // combinational reads, x0 reads as zero
  assign bus.rd1 = (bus.rs1 == '0) ? '0 : regs[bus.rs1];
  assign bus.rd2 = (bus.rs2 == '0) ? '0 : regs[bus.rs2];

endmodule

`default_nettype wire

/* design/r5p_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module r5p_alu (
  input  wire r5p_pkg::alu_op_t op,
  input  wire r5p_pkg::xw_t     rs1,
  input  wire r5p_pkg::xw_t     rs2,
  output r5p_pkg::xw_t          rd,
  output r5p_pkg::xw_t          sum
);

  logic [4:0] sh;

  // shift amount from the low five bits
  assign sh = rs2[4:0];

  // plain adder, also feeds branch targets and load/store addresses
  assign sum = rs1 + rs2;

  always_comb begin
    case (op)
      r5p_pkg::ADD:   rd = sum;
      r5p_pkg::SUB:   rd = rs1 - rs2;
      r5p_pkg::SLL:   rd = rs1 << sh;
      r5p_pkg::SLT:   rd = {31'd0, $signed(rs1) < $signed(rs2)};
      r5p_pkg::SLTU:  rd = {31'd0, rs1 < rs2};
      r5p_pkg::XOR:   rd = rs1 ^ rs2;
      r5p_pkg::SRL:   rd = rs1 >> sh;
      // arithmetic shift keeps the sign
      r5p_pkg::SRA:   rd = $unsigned($signed(rs1) >>> sh);
      r5p_pkg::OR:    rd = rs1 | rs2;
      r5p_pkg::AND:   rd = rs1 & rs2;
      r5p_pkg::PASS2: rd = rs2;
      default:        rd = sum;
    endcase
  end

endmodule

`default_nettype wire

/* design/r5p_br.sv */
`timescale 1ns/1ps
`default_nettype none

module r5p_br (
  input  wire r5p_pkg::br_op_t op,
  input  wire r5p_pkg::xw_t    rs1,
  input  wire r5p_pkg::xw_t    rs2,
  output logic                 tkn
);

  logic eq;
  logic lt;
  logic ltu;

  assign eq  = (rs1 == rs2);
  assign lt  = ($signed(rs1) < $signed(rs2));
  assign ltu = (rs1 < rs2);

  always_comb begin
    case (op)
      r5p_pkg::BEQ:  tkn = eq;
      r5p_pkg::BNE:  tkn = !eq;
      r5p_pkg::BLT:  tkn = lt;
      r5p_pkg::BGE:  tkn = !lt;
      r5p_pkg::BLTU: tkn = ltu;
      r5p_pkg::BGEU: tkn = !ltu;
      // jumps always go
      r5p_pkg::JMP:  tkn = 1'b1;
      default:       tkn = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* design/r5p_core.sv */
`timescale 1ns/1ps
`default_nettype none

module r5p_core #(
  parameter r5p_pkg::adr_t PC0   = 32'h0000_0000,
  parameter int unsigned   RF_AW = 5
)(
  input  wire logic            clk,
  input  wire logic            rst,
  // program bus
  output logic                 if_req,
  output r5p_pkg::adr_t        if_adr,
  input  wire r5p_pkg::op32_t  if_rdt,
  input  wire logic            if_ack,
  // load/store bus
  output logic                 ls_req,
  output logic                 ls_wen,
  output r5p_pkg::adr_t        ls_adr,
  output r5p_pkg::sel_t        ls_sel,
  output r5p_pkg::xw_t         ls_wdt,
  input  wire r5p_pkg::xw_t    ls_rdt,
  input  wire logic            ls_ack
);

  // fetch and retire
  logic          vld;
  logic          retire;
  r5p_pkg::adr_t pc;
  r5p_pkg::adr_t pc4;
  r5p_pkg::adr_t pc_nxt;
  // decode
  r5p_pkg::ctl_t ctl;
  logic          ill;
  logic          tkn;
  // execute
  r5p_pkg::xw_t  alu_rs1;
  r5p_pkg::xw_t  alu_rs2;
  r5p_pkg::xw_t  alu_rd;
  r5p_pkg::xw_t  alu_sum;
  // byte offset inside the word
  logic [1:0]    bo;

  r5p_gpr_if #(.RF_AW(RF_AW)) gpr_bus ();

  //////////////////////////////
  // fetch and program counter
  //////////////////////////////

  // request rises in the first cycle out of reset
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      if_req <= 1'b0;
    end else begin
      if_req <= 1'b1;
    end
  end

  assign if_adr = pc;
  assign vld    = if_req & if_ack;
  // a data access holds the instruction until acknowledged
  assign retire = vld & (~ls_req | ls_ack);
  assign pc4    = pc + 32'd4;

  // taken branch or jump goes to the adder, bit 0 dropped for JALR
  always_comb begin
    if (!ill && ctl.pc == r5p_pkg::PC_ALU && tkn) begin
      pc_nxt = {alu_sum[31:1], 1'b0};
    end else begin
      pc_nxt = pc4;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= PC0;
    end else if (retire) begin
      pc <= pc_nxt;
    end
  end

  //////////////////////////////
  // decode and registers
  //////////////////////////////

  r5p_dec dec_i (
    .op  (if_rdt),
    .ctl (ctl),
    .ill (ill)
  );

  assign gpr_bus.rs1 = if_rdt[15 +: RF_AW];
  assign gpr_bus.rs2 = if_rdt[20 +: RF_AW];
  assign gpr_bus.rd  = if_rdt[7 +: RF_AW];
  // file written only at retire
  assign gpr_bus.we  = retire & ~ill & (ctl.wb != r5p_pkg::WB_NONE);

  // write-back select
  always_comb begin
    case (ctl.wb)
      r5p_pkg::WB_ALU: gpr_bus.wd = alu_rd;
      r5p_pkg::WB_MEM: gpr_bus.wd = ls_rdt;
      r5p_pkg::WB_PCN: gpr_bus.wd = pc4;
      default:         gpr_bus.wd = '0;
    endcase
  end

  r5p_gpr #(
    .RF_AW (RF_AW)
  ) gpr_i (
    .clk (clk),
    .rst (rst),
    .bus (gpr_bus)
  );

  //////////////////////////////
  // execute
  //////////////////////////////

  // operand muxes
  always_comb begin
    case (ctl.a1)
      r5p_pkg::A1_PC: alu_rs1 = pc;
      default:        alu_rs1 = gpr_bus.rd1;
    endcase
    case (ctl.a2)
      r5p_pkg::A2_IMM: alu_rs2 = ctl.imm;
      default:         alu_rs2 = gpr_bus.rd2;
    endcase
  end

  r5p_alu alu_i (
    .op  (ctl.alu),
    .rs1 (alu_rs1),
    .rs2 (alu_rs2),
    .rd  (alu_rd),
    .sum (alu_sum)
  );

  // compare always on register values
  r5p_br br_i (
    .op  (ctl.br),
    .rs1 (gpr_bus.rd1),
    .rs2 (gpr_bus.rd2),
    .tkn (tkn)
  );

  //////////////////////////////
  // load/store
  //////////////////////////////

  assign ls_req = vld & ctl.ls_en & ~ill;
  assign ls_wen = ls_req & ctl.ls_we;
  // word aligned address, lanes pick the bytes
  assign ls_adr = {alu_sum[31:2], 2'b00};
  assign bo     = alu_sum[1:0];

  // lanes shifted by the offset, data copied into every lane
  always_comb begin
    case (ctl.sz)
      r5p_pkg::SZ_B: begin
        ls_sel = 4'b0001 << bo;
        ls_wdt = {4{gpr_bus.rd2[7:0]}};
      end
      r5p_pkg::SZ_H: begin
        ls_sel = 4'b0011 << bo;
        ls_wdt = {2{gpr_bus.rd2[15:0]}};
      end
      default: begin
        ls_sel = 4'b1111;
        ls_wdt = gpr_bus.rd2;
      end
    endcase
  end

endmodule

`default_nettype wire

/* sim/r5p_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module r5p_chk (
  input wire logic          clk,
  input wire logic          rst,
  input wire logic          if_req,
  input wire r5p_pkg::adr_t if_adr,
  input wire logic          if_ack,
  input wire logic          ls_req,
  input wire r5p_pkg::sel_t ls_sel,
  input wire logic          we
);

  // failed assertions so far
  int unsigned fails = 0;

  // nothing leaves the core while reset is held
  a_rst_quiet: assert property (@(posedge clk) rst |-> (!if_req && !ls_req && !we))
    else begin
      $error("bus request or register write during reset");
      fails++;
    end

  // a data access always selects at least one lane
  a_sel_nonzero: assert property (@(posedge clk) disable iff (rst) ls_req |-> (ls_sel != '0))
    else begin
      $error("load/store request with empty byte select");
      fails++;
    end

  // fetch address held while the program bus stalls
  a_fetch_hold: assert property (@(posedge clk) disable iff (rst)
    (if_req && !if_ack) |=> $stable(if_adr))
    else begin
      $error("fetch address moved during a program bus stall");
      fails++;
    end

endmodule

bind r5p_core r5p_chk chk_i (
  .clk    (clk),
  .rst    (rst),
  .if_req (if_req),
  .if_adr (if_adr),
  .if_ack (if_ack),
  .ls_req (ls_req),
  .ls_sel (ls_sel),
  .we     (gpr_bus.we)
);

`default_nettype wire

/* sim/r5p_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module r5p_tb;

  localparam logic [31:0] PC0  = 32'h0000_0000;
  // store to this word ends a program
  localparam logic [31:0] MARK = 32'h0000_03fc;
  localparam logic [6:0]  OP = 7'h33, OPI = 7'h13, LUI = 7'h37, AUIPC = 7'h17;
  localparam logic [6:0]  JALR = 7'h67, LD = 7'h03;

  logic clk, rst, if_req, if_ack, ls_req, ls_wen, ls_ack, stall;
  logic [31:0] if_adr, if_rdt, ls_adr, ls_wdt, ls_rdt;
  logic [3:0]  ls_sel;
  logic [31:0] imem [256];
  logic [31:0] dmem [256];
  logic [31:0] mm [256];
  logic [31:0] exp_adr [$];
  logic [3:0]  exp_sel [$];
  logic [31:0] exp_dat [$];
  int wp, off, errs, cmp_errs, mark_cnt, passed, failed;

  r5p_core #(.PC0(PC0), .RF_AW(5)) r5p_core_i (
    .clk(clk), .rst(rst),
    .if_req(if_req), .if_adr(if_adr), .if_rdt(if_rdt), .if_ack(if_ack),
    .ls_req(ls_req), .ls_wen(ls_wen), .ls_adr(ls_adr), .ls_sel(ls_sel),
    .ls_wdt(ls_wdt), .ls_rdt(ls_rdt), .ls_ack(ls_ack)
  );

  always #4 clk = ~clk;

  // memories answer in the same cycle
  assign if_rdt = imem[if_adr[9:2]];
  assign ls_rdt = dmem[ls_adr[9:2]];

  // handshakes about 30% low when stalling
  initial begin
    void'($urandom(60830));
    forever begin
      @(posedge clk);
      #1;
      if_ack = stall ? (($urandom % 10) >= 3) : 1'b1;
      ls_ack = stall ? (($urandom % 10) >= 3) : 1'b1;
    end
  end

  //////////////////////////////
  // encoders
  //////////////////////////////

  function automatic logic [31:0] rtype(int f7, int rs2, int rs1, int f3, int rd, logic [6:0] o);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], o};
  endfunction
  function automatic logic [31:0] itype(int imm, int rs1, int f3, int rd, logic [6:0] o);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], o};
  endfunction
  function automatic logic [31:0] stype(int imm, int rs2, int rs1, int f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
  endfunction
  function automatic logic [31:0] btype(int imm, int rs2, int rs1, int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
  endfunction
  function automatic logic [31:0] utype(int imm, int rd, logic [6:0] o);
    return {imm[19:0], rd[4:0], o};
  endfunction
  function automatic logic [31:0] jtype(int imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
  endfunction

  // preload pattern over the whole word index
  function automatic logic [31:0] fill_word(int i);
    return (i * 32'h9e37_79b9) ^ 32'h5a5a_0000 ^ i;
  endfunction

  //////////////////////////////
  // reference model
  //////////////////////////////

  function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] a, b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'd0, $signed(a) < $signed(b)};
      3'd3: return {31'd0, a < b};
      3'd4: return a ^ b;
      3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic br_ref(logic [2:0] f3, logic [31:0] a, b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  // runs the program up to the marker store and queues every store
  function automatic void model_run();
    logic [31:0] r [32];
    logic [31:0] pc, ins, a, b, v, npc, ea, ii, is, ib, ij, dat;
    logic [3:0] sel;
    logic wr;
    for (int i = 0; i < 32; i++) r[i] = '0;
    for (int i = 0; i < 256; i++) mm[i] = fill_word(i);
    pc = PC0;
    for (int n = 0; n < 5000; n++) begin
      ins = imem[pc[9:2]];
      a   = r[ins[19:15]];
      b   = r[ins[24:20]];
      ii  = {{20{ins[31]}}, ins[31:20]};
      is  = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      ib  = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      ij  = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      npc = pc + 4;
      wr  = 1'b1;
      v   = '0;
      case (ins[6:0])
        LUI:     v = {ins[31:12], 12'h000};
        AUIPC:   v = pc + {ins[31:12], 12'h000};
        7'h6f: begin
          v   = pc + 4;
          npc = pc + ij;
        end
        JALR: begin
          v   = pc + 4;
          npc = (a + ii) & ~32'h1;
        end
        7'h63: begin
          wr = 1'b0;
          if (br_ref(ins[14:12], a, b)) npc = pc + ib;
        end
        LD: begin
          ea = a + ii;
          v  = mm[ea[9:2]];
        end
        7'h23: begin
          wr = 1'b0;
          ea = a + is;
          // narrow data copied into every lane
          case (ins[14:12])
            3'd0: begin
              sel = 4'b0001 << ea[1:0];
              dat = {4{b[7:0]}};
            end
            3'd1: begin
              sel = 4'b0011 << ea[1:0];
              dat = {2{b[15:0]}};
            end
            default: begin
              sel = 4'b1111;
              dat = b;
            end
          endcase
          exp_adr.push_back({ea[31:2], 2'b00});
          exp_sel.push_back(sel);
          exp_dat.push_back(dat);
          for (int k = 0; k < 4; k++) begin
            if (sel[k]) mm[ea[9:2]][8*k +: 8] = dat[8*k +: 8];
          end
          if ({ea[31:2], 2'b00} == MARK) return;
        end
        OPI:     v = alu_ref(ins[14:12], ins[14:12] == 3'd5 && ins[30], a, ii);
        OP:      v = alu_ref(ins[14:12], ins[30], a, b);
        default: wr = 1'b0;
      endcase
      if (wr && ins[11:7] != 5'd0) r[ins[11:7]] = v;
      pc = npc;
    end
  endfunction

  //////////////////////////////
  // store compare
  //////////////////////////////

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 256; i++) dmem[i] = fill_word(i);
    end else if (if_req && if_ack && ls_req && ls_wen && ls_ack) begin
      assert (exp_adr.size() != 0) else begin
        $display("store to %h that the model does not make", ls_adr);
        cmp_errs++;
      end
      if (exp_adr.size() != 0) begin
        assert (ls_adr == exp_adr[0]) else begin
          $display("[ERROR] ls_adr expected %h got %h", exp_adr[0], ls_adr);
          cmp_errs++;
        end
        assert (ls_sel == exp_sel[0]) else begin
          $display("[ERROR] ls_sel expected %h got %h", exp_sel[0], ls_sel);
          cmp_errs++;
        end
        assert (ls_wdt == exp_dat[0]) else begin
          $display("[ERROR] ls_wdt expected %h got %h", exp_dat[0], ls_wdt);
          cmp_errs++;
        end
        void'(exp_adr.pop_front());
        void'(exp_sel.pop_front());
        void'(exp_dat.pop_front());
      end
      for (int k = 0; k < 4; k++) begin
        if (ls_sel[k]) dmem[ls_adr[9:2]][8*k +: 8] = ls_wdt[8*k +: 8];
      end
      if (ls_adr == MARK) mark_cnt++;
    end
  end

  //////////////////////////////
  // programs
  //////////////////////////////

  task automatic put(logic [31:0] w);
    imem[wp] = w;
    wp++;
  endtask

  // instruction into x3 and x3 stored to the next slot
  task automatic put_st(logic [31:0] w);
    put(w);
    put(stype(off, 3, 0, 2));
    off += 4;
  endtask

  task automatic arith_prog();
    put(itype(32'h123, 0, 0, 1, OPI));
    put(itype(-5, 0, 0, 2, OPI));
    put(itype(7, 0, 0, 5, OPI));
    for (int f = 0; f < 8; f++) put_st(rtype(0, 2, 1, f, 3, OP));
    put_st(rtype(32, 2, 1, 0, 3, OP));
    put_st(rtype(32, 5, 2, 5, 3, OP));
    put_st(rtype(0, 5, 2, 5, 3, OP));
    for (int f = 0; f < 8; f++) begin
      if (f != 1 && f != 5) put_st(itype(32'h8a5, 2, f, 3, OPI));
    end
    put_st(itype(3, 2, 1, 3, OPI));
    put_st(itype(9, 2, 5, 3, OPI));
    put_st(itype(32'h409, 2, 5, 3, OPI));
    put_st(utype(32'habcde, 3, LUI));
    put_st(utype(32'h12, 3, AUIPC));
  endtask

  task automatic flow_prog();
    int f3s [6] = '{0, 1, 4, 5, 6, 7};
    put(itype(-5, 0, 0, 1, OPI));
    put(itype(3, 0, 0, 2, OPI));
    put(itype(3, 0, 0, 3, OPI));
    // a taken branch skips the store of the counter
    for (int k = 0; k < 6; k++) begin
      for (int p = 0; p < 3; p++) begin
        put(itype(1, 11, 0, 11, OPI));
        put(btype(8, p == 0 ? 3 : p == 1 ? 2 : 1, p == 0 ? 2 : p == 1 ? 1 : 2, f3s[k]));
        put(stype(off, 11, 0, 2));
        off += 4;
      end
    end
    put(jtype(8, 12));
    put(itype(100, 0, 0, 11, OPI));
    put(stype(off, 12, 0, 2));
    put(utype(0, 13, AUIPC));
    put(itype(12, 13, 0, 14, JALR));
    put(itype(100, 0, 0, 11, OPI));
    put(stype(off + 4, 14, 0, 2));
    put(stype(off + 8, 11, 0, 2));
    // backward loop of three passes
    put(itype(3, 0, 0, 15, OPI));
    put(itype(-1, 15, 0, 15, OPI));
    put(stype(off + 12, 15, 0, 2));
    put(btype(-8, 0, 15, 1));
  endtask

  task automatic loads_prog();
    put(itype(32'h40, 0, 2, 1, LD));
    put(itype(32'h44, 0, 2, 2, LD));
    put_st(rtype(0, 2, 1, 0, 3, OP));
    put_st(rtype(0, 2, 1, 4, 3, OP));
    put(stype(32'h80, 1, 0, 2));
    put(itype(32'h80, 0, 2, 4, LD));
    put_st(rtype(32, 2, 4, 0, 3, OP));
    put(itype(32'h40, 0, 0, 6, OPI));
    put(itype(8, 6, 2, 5, LD));
    put_st(rtype(0, 1, 5, 6, 3, OP));
  endtask

  task automatic narrow_prog();
    put(utype(32'h89abd, 1, LUI));
    put(itype(-32'h211, 1, 0, 1, OPI));
    for (int k = 0; k < 4; k++) put(stype(32'h200 + k, 1, 0, 0));
    put(stype(32'h210, 1, 0, 1));
    put(stype(32'h212, 1, 0, 1));
    put(stype(32'h220, 1, 0, 2));
    put(itype(32'h231, 0, 0, 6, OPI));
    put(stype(1, 1, 6, 0));
    put(stype(1, 1, 6, 1));
    put(itype(32'h200, 0, 2, 3, LD));
    put(stype(32'h240, 3, 0, 2));
  endtask

  //////////////////////////////
  // test flow
  //////////////////////////////

  task automatic apply_reset();
    int n;
    @(posedge clk);
    #1 rst = 1'b1;
    repeat (2) begin
      @(negedge clk);
      assert (!if_req && !ls_req) else begin
        $display("[ERROR] if_req/ls_req expected 0 in reset got %h/%h", if_req, ls_req);
        errs++;
      end
      @(posedge clk);
    end
    #1 rst = 1'b0;
    for (n = 0; n < 20; n++) begin
      @(negedge clk);
      if (if_req) break;
    end
    assert (n < 20) else begin
      $display("no fetch request after reset");
      errs++;
    end
    assert (if_adr == PC0) else begin
      $display("[ERROR] if_adr expected %h got %h", PC0, if_adr);
      errs++;
    end
  endtask

  task automatic run_prog(string name, int prog, logic st);
    int n, base, seen;
    base = errs + cmp_errs;
    for (int i = 0; i < 256; i++) imem[i] = 32'h0000_006f;
    wp  = 0;
    off = 32'h100;
    case (prog)
      0: arith_prog();
      1: flow_prog();
      2: loads_prog();
      default: narrow_prog();
    endcase
    // marker store and a spin in place
    put(stype(MARK, 0, 0, 2));
    put(32'h0000_006f);
    exp_adr.delete();
    exp_sel.delete();
    exp_dat.delete();
    model_run();
    stall = st;
    seen  = mark_cnt;
    apply_reset();
    for (n = 0; n < 4000; n++) begin
      @(negedge clk);
      if (mark_cnt != seen) break;
    end
    assert (n < 4000) else begin
      $display("timeout waiting for the end-of-program store");
      errs++;
    end
    assert (exp_adr.size() == 0) else begin
      $display("%0d expected stores never appeared", exp_adr.size());
      errs++;
    end
    for (int i = 0; i < 256; i++) begin
      assert (dmem[i] == mm[i]) else begin
        $display("[ERROR] dmem[%h] expected %h got %h", i, mm[i], dmem[i]);
        errs++;
      end
    end
    stall = 1'b0;
    n = errs + cmp_errs - base;
    $display("test %s: %0d errors", name, n);
    if (n == 0) passed++;
    else failed++;
  endtask

  initial begin
    clk    = 1'b0;
    rst    = 1'b1;
    if_ack = 1'b0;
    ls_ack = 1'b0;
    stall  = 1'b0;
    errs = 0;
    cmp_errs = 0;
    mark_cnt = 0;
    passed = 0;
    failed = 0;
    for (int i = 0; i < 256; i++) imem[i] = 32'h0000_006f;
    begin
      int base;
      base = errs;
      apply_reset();
      $display("test reset: %0d errors", errs - base);
      if (errs == base) passed++;
      else failed++;
    end
    run_prog("arith", 0, 1'b0);
    run_prog("flow", 1, 1'b0);
    run_prog("loads", 2, 1'b0);
    run_prog("narrow", 3, 1'b0);
    // same programs under random stalls
    for (int p = 0; p < 4; p++) run_prog($sformatf("stall%0d", p), p, 1'b1);
    // protocol assertions bound into the core
    assert (r5p_core_i.chk_i.fails == 0) else begin
      $display("bound protocol assertions failed %0d times", r5p_core_i.chk_i.fails);
      errs++;
    end
    $display("tests passed %0d, failed %0d, errors %0d", passed, failed, errs + cmp_errs);
    if (failed == 0 && errs + cmp_errs == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
design/r5p_pkg.sv
design/r5p_gpr_if.sv
design/r5p_dec.sv
design/r5p_gpr.sv
design/r5p_alu.sv
design/r5p_br.sv
design/r5p_core.sv
sim/r5p_chk.sv
sim/r5p_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module r5p_tb -o r5p_sim

out=$(./obj_dir/r5p_sim)
echo "$out"

if echo "$out" | grep -qx "sim passed"; then
  exit 0
else
  exit 1
fi
